//--- src.f
source/rvfi_csr_pkg.sv
source/csr_insn_decode.sv
source/csr_mask_calc.sv
source/csr_rule_check.sv
source/rvfi_csrw_monitor.sv
testbench/rvfi_csrw_chk.sv
testbench/csrw_scoreboard.sv
testbench/tb_rvfi_csrw_monitor.sv

//--- Makefile
# Verilator build, run, lint and clean for the RVFI CSR-write monitor

VERILATOR ?= verilator
VFLAGS    ?= --binary --assert --timing
LINTFLAGS ?= --lint-only -Wall --timing
TOP       := tb_rvfi_csrw_monitor
FILELIST  := src.f
OBJ_DIR   := obj_dir
LOG       := sim.log

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: build
	./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1 || true
	@cat $(LOG)
	@if grep -q "Test failures found" $(LOG); then echo "Simulation failed"; exit 1; fi
	@if ! grep -q "All tests passed!" $(LOG); then echo "Simulation ended early"; exit 1; fi

lint:
	$(VERILATOR) $(LINTFLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

//--- testbench/tb_rvfi_csrw_monitor.sv
// Testbench top for the CSR-write monitor, drives LFSR packets and reports the scoreboard result

module tb_rvfi_csrw_monitor import rvfi_csr_pkg::*; ();

	localparam logic [11:0] MON_ADDR = 12'hB00;
	localparam int          COUNT_W  = 16;
	localparam int          NUM_PKTS = 400;
	// Leading packets all hit the CSR, which gives a back-to-back burst
	localparam int          BURST    = 16;
	localparam int          TIMEOUT  = NUM_PKTS * 2 + 100;

	logic               clock;
	logic               rst_n;
	rvfi_pkt_t          rvfi;
	rvfi_pkt_t          next_pkt;
	logic               result_valid;
	csr_result_t        result;
	logic [COUNT_W-1:0] fail_count;
	logic [31:0]        lfsr_state;
	logic [15:0]        seq_order;
	int                 value_errors;
	int                 extra_results;
	int                 pending;
	int                 assert_fails;
	int                 cycles = 0;

	always #10 clock = ~clock;

	rvfi_csrw_monitor u_rvfi_csrw_monitor (
		.clock        (clock),
		.rst_n        (rst_n),
		.rvfi         (rvfi),
		.result_valid (result_valid),
		.result       (result),
		.fail_count   (fail_count)
	);

	csrw_scoreboard #(
		.CSR_ADDR (MON_ADDR),
		.COUNT_W  (COUNT_W)
	) u_csrw_scoreboard (
		.clock         (clock),
		.rst_n         (rst_n),
		.rvfi          (rvfi),
		.result_valid  (result_valid),
		.result        (result),
		.fail_count    (fail_count),
		.value_errors  (value_errors),
		.extra_results (extra_results),
		.pending       (pending)
	);

	// Failures of the bound timing and counter assertions
	assign assert_fails = u_rvfi_csrw_monitor.u_rvfi_csrw_chk.assert_fails;

	// Right-shifting Galois form with taps 32, 22, 2 and 1
	function automatic logic [31:0] lfsr_step(input logic [31:0] s);
		return s[0] ? ((s >> 1) ^ 32'h80200003) : (s >> 1);
	endfunction

	task automatic take_bits(input int n, output logic [31:0] val);
		val = '0;
		for (int i = 0; i < n; i++) begin
			val        = {val[30:0], lfsr_state[0]};
			lfsr_state = lfsr_step(lfsr_state);
		end
	endtask

	// Kind 0 idles, 1 to 3 break the opcode, funct3 or address, 4 to 7 hit the CSR
	// Fault 4 to 7 corrupts rd data, read mask, write data or the mask coverage
	task automatic make_packet(input logic force_match, output rvfi_pkt_t p);
		logic [31:0]     r;
		logic [2:0]      kind;
		logic [2:0]      fault;
		logic [1:0]      op;
		logic            imm;
		logic [4:0]      rs1;
		logic [4:0]      rd;
		logic [11:0]     addr;
		logic [6:0]      opcode;
		logic [XLEN-1:0] old_val;
		logic [XLEN-1:0] src;
		logic [XLEN-1:0] operand;
		logic [XLEN-1:0] new_val;
		logic [XLEN-1:0] noise;
		take_bits(3, r);
		kind = force_match ? 3'd4 : r[2:0];
		take_bits(2, r);
		op = (r[1:0] == 2'b00) ? F3_RW : r[1:0];
		take_bits(1, r);
		imm = r[0];
		take_bits(5, r);
		rs1 = r[4:0];
		take_bits(7, r);
		rd = (r[6:5] == 2'b00) ? 5'd0 : r[4:0];
		take_bits(32, r);
		old_val = r;
		take_bits(32, r);
		src = r;
		take_bits(32, r);
		noise = (r == '0) ? 32'h1 : r;
		take_bits(3, r);
		fault  = r[2:0];
		opcode = OPC_SYSTEM;
		addr   = MON_ADDR;
		case (kind)
			3'd1: begin
				take_bits(7, r);
				opcode = r[6:0];
			end
			3'd2: op = 2'b00;
			3'd3: begin
				take_bits(12, r);
				addr = r[11:0];
			end
			default: ;
		endcase
		// A consistent core writes the CSR as the operation demands and returns the old value
		operand = imm ? {{(XLEN-5){1'b0}}, rs1} : src;
		case (op)
			F3_RS: new_val = old_val | operand;
			F3_RC: new_val = old_val & ~operand;
			default: new_val = operand;
		endcase
		p.valid     = (kind != 3'd0);
		p.order     = seq_order;
		p.insn      = {addr, rs1, imm, op, rd, opcode};
		p.rs1_rdata = src;
		p.rd_addr   = rd;
		p.rd_wdata  = (rd == 5'd0) ? '0 : old_val;
		p.csr_rmask = '1;
		p.csr_rdata = old_val;
		p.csr_wmask = '1;
		p.csr_wdata = new_val;
		case (fault)
			3'd4: p.rd_wdata ^= noise;
			3'd5: p.csr_rmask ^= noise;
			3'd6: p.csr_wdata ^= noise;
			3'd7: begin
				p.csr_rmask = '0;
				p.csr_wmask = ~noise;
			end
			default: ;
		endcase
		if (p.valid) seq_order = seq_order + 16'd1;
	endtask

	// Bounds the run in case the pipeline never drains
	always @(posedge clock) begin
		cycles++;
		if (cycles > TIMEOUT) begin
			$display("Timeout after %0d cycles with %0d results still outstanding", cycles, pending);
			$display("Test failures found");
			$finish;
		end
	end

	initial begin
		clock      = 1'b0;
		rst_n      = 1'b0;
		rvfi       = '0;
		lfsr_state = 32'hd2bc;
		seq_order  = 16'd0;
		repeat (5) @(posedge clock);
		#2 rst_n = 1'b1;
		for (int i = 0; i < NUM_PKTS; i++) begin
			@(posedge clock);
			#2;
			make_packet(i < BURST, next_pkt);
			rvfi = next_pkt;
		end
		@(posedge clock);
		#2 rvfi = '0;
		while (pending != 0) @(posedge clock);
		// A few spare edges catch any result that should not be there
		repeat (4) @(posedge clock);
		$display("Done: %0d value errors, %0d extra, %0d missing, %0d assertion failures",
			value_errors, extra_results, pending, assert_fails);
		if (value_errors + extra_results + pending + assert_fails == 0) begin
			$display("All tests passed!");
		end else begin
			$display("Test failures found");
		end
		$finish;
	end

endmodule

//--- testbench/csrw_scoreboard.sv
// Scoreboard for the CSR-write monitor, predicts each result from the RVFI packet and compares

module csrw_scoreboard import rvfi_csr_pkg::*; #(
	parameter logic [11:0] CSR_ADDR = 12'hB00,
	parameter int          COUNT_W  = 16
) (
	input  logic               clock,
	input  logic               rst_n,
	input  rvfi_pkt_t          rvfi,
	input  logic               result_valid,
	input  csr_result_t        result,
	input  logic [COUNT_W-1:0] fail_count,
	output int                 value_errors,
	output int                 extra_results,
	output int                 pending
);

	// One outstanding prediction, stamped with the edge at which its packet was seen
	typedef struct packed {
		logic [31:0] cycle;
		logic [15:0] order;
		csr_viol_t   viol;
	} expect_t;

	expect_t            exp_q[$];
	expect_t            head;
	expect_t            fresh;
	logic [COUNT_W-1:0] exp_count;
	logic [5:0]         exp_flags;
	logic [5:0]         got_flags;
	int                 cycle_no = 0;
	int                 n_value = 0;
	int                 n_extra = 0;

	// Flag names from the most significant struct bit down
	string flag_name [0:5] = '{"result.viol.rd0_nonzero", "result.viol.rmask_partial",
		"result.viol.rdata_mismatch", "result.viol.mask_uncovered",
		"result.viol.set_missing", "result.viol.clear_missing"};

	assign value_errors  = n_value;
	assign extra_results = n_extra;
	assign pending       = exp_q.size();

	// A packet is checked only if it is a Zicsr instruction on the watched CSR
	function automatic logic accepts(rvfi_pkt_t p);
		return p.valid && (p.insn[6:0] == OPC_SYSTEM) && (p.insn[13:12] != 2'b00) &&
			(p.insn[31:20] == CSR_ADDR);
	endfunction

	// Reference model of the six rules, worked bit by bit over the CSR
	function automatic csr_viol_t expect_viol(rvfi_pkt_t p);
		logic [XLEN-1:0] opnd;
		logic [XLEN-1:0] set_m;
		logic [XLEN-1:0] clr_m;
		logic [XLEN-1:0] seen;
		logic [XLEN-1:0] after;
		csr_viol_t       v;
		opnd  = p.insn[14] ? XLEN'(p.insn[19:15]) : p.rs1_rdata;
		set_m = '0;
		clr_m = '0;
		if (p.insn[13:12] == F3_RW || p.insn[13:12] == F3_RS) set_m = opnd;
		if (p.insn[13:12] == F3_RW) clr_m = ~opnd;
		if (p.insn[13:12] == F3_RC) clr_m = opnd;
		for (int i = 0; i < XLEN; i++) begin
			// A bit counts as seen if it was read or written; written bits show the new value
			seen[i]  = p.csr_rmask[i] | p.csr_wmask[i];
			after[i] = p.csr_wmask[i] ? p.csr_wdata[i] : p.csr_rdata[i];
		end
		v.rd0_nonzero    = (p.rd_addr == 5'd0) && (p.rd_wdata != '0);
		v.rmask_partial  = (p.rd_addr != 5'd0) && (p.csr_rmask != '1);
		v.rdata_mismatch = (p.rd_addr != 5'd0) && (p.csr_rdata != p.rd_wdata);
		v.mask_uncovered = ((set_m | clr_m) & ~seen) != '0;
		v.set_missing    = (set_m & ~after) != '0;
		v.clear_missing  = (clr_m & after) != '0;
		return v;
	endfunction

	task automatic check_field(input string name, input logic [31:0] exp, input logic [31:0] act);
		if (exp !== act) begin
			$display("ERROR time=%0t signal=%s expected=%0h actual=%0h", $time, name, exp, act);
			n_value++;
		end
	endtask

	// Sampled on the rising edge, where stimulus and DUT outputs are both settled
	always @(posedge clock) begin
		cycle_no++;
		if (!rst_n) begin
			check_field("result_valid", 32'd0, 32'(result_valid));
			check_field("fail_count", 32'd0, 32'(fail_count));
			exp_count = '0;
			exp_q.delete();
		end else begin
			if (result_valid && exp_q.size() == 0) begin
				$display("Result with order %0h arrived while no instruction was outstanding",
					result.order);
				n_extra++;
			end else if (result_valid) begin
				head      = exp_q.pop_front();
				exp_flags = head.viol;
				got_flags = result.viol;
				check_field("result.order", 32'(head.order), 32'(result.order));
				if (cycle_no - int'(head.cycle) != 3) begin
					$display("Result for order %0h came %0d cycles after its packet, not 3",
						head.order, cycle_no - int'(head.cycle));
					n_value++;
				end
				for (int k = 0; k < 6; k++) begin
					check_field(flag_name[k], 32'(exp_flags[5-k]), 32'(got_flags[5-k]));
				end
				if (exp_flags != '0 && exp_count != '1) exp_count = exp_count + 1'b1;
			end
			check_field("fail_count", 32'(exp_count), 32'(fail_count));
			if (accepts(rvfi)) begin
				fresh.cycle = 32'(cycle_no);
				fresh.order = rvfi.order;
				fresh.viol  = expect_viol(rvfi);
				exp_q.push_back(fresh);
			end
		end
	end

endmodule

//--- testbench/rvfi_csrw_chk.sv
// Timing and counter assertions for the CSR-write monitor, attached to its top level by bind

module rvfi_csrw_chk #(
	parameter int COUNT_W = 16
) (
	input logic               clock,
	input logic               rst_n,
	input logic               dec_valid,
	input logic               mask_valid,
	input logic               result_valid,
	input logic [COUNT_W-1:0] fail_count
);

	// Number of assertion failures seen so far
	int assert_fails = 0;

	// No result may be published while the pipeline is held in reset
	assert property (@(posedge clock) !rst_n |-> !result_valid)
		else begin
			$error("result_valid high during reset");
			assert_fails++;
		end

	// A decoded instruction moves to the mask stage on the very next edge
	assert property (@(posedge clock) disable iff (!rst_n) dec_valid |=> mask_valid)
		else begin
			$error("mask_valid missing one cycle after dec_valid");
			assert_fails++;
		end

	// Two edges after decode the result strobe has to be up
	assert property (@(posedge clock) disable iff (!rst_n) $past(dec_valid, 2) |-> result_valid)
		else begin
			$error("result_valid missing two cycles after dec_valid");
			assert_fails++;
		end

	// Saturating counter only moves up or holds
	assert property (@(posedge clock) disable iff (!rst_n) fail_count >= $past(fail_count))
		else begin
			$error("fail_count decreased");
			assert_fails++;
		end

endmodule

bind rvfi_csrw_monitor rvfi_csrw_chk #(
	.COUNT_W (COUNT_W)
) u_rvfi_csrw_chk (
	.clock        (clock),
	.rst_n        (rst_n),
	.dec_valid    (dec_valid),
	.mask_valid   (mask_valid),
	.result_valid (result_valid),
	.fail_count   (fail_count)
);

//--- source/rvfi_csrw_monitor.sv
// Top level of the CSR-write monitor, chains decode, mask build and rule check on one RVFI port

module rvfi_csrw_monitor import rvfi_csr_pkg::*; #(
	// CSR under check, handed to the decode stage
	parameter logic [11:0] CSR_ADDR = 12'hB00,
	// Failure counter width, handed to the rule stage
	parameter int          COUNT_W  = 16
) (
	input  logic               clock,
	input  logic               rst_n,
	input  rvfi_pkt_t          rvfi,
	output logic               result_valid,
	output csr_result_t        result,
	output logic [COUNT_W-1:0] fail_count
);

	// Stage 1 to stage 2
	logic     dec_valid;
	csr_dec_t dec;

	// Stage 2 to stage 3
	logic      mask_valid;
	csr_mask_t mask;

	// The core is never stalled, so each stage is a bare valid strobe plus payload
	// Total latency from a sampled packet to its result is three cycles
	csr_insn_decode #(
		.CSR_ADDR (CSR_ADDR)
	) u_csr_insn_decode (
		.clock     (clock),
		.rst_n     (rst_n),
		.rvfi      (rvfi),
		.dec_valid (dec_valid),
		.dec       (dec)
	);

	csr_mask_calc u_csr_mask_calc (
		.clock      (clock),
		.rst_n      (rst_n),
		.dec_valid  (dec_valid),
		.dec        (dec),
		.mask_valid (mask_valid),
		.mask       (mask)
	);

	csr_rule_check #(
		.COUNT_W (COUNT_W)
	) u_csr_rule_check (
		.clock        (clock),
		.rst_n        (rst_n),
		.mask_valid   (mask_valid),
		.mask         (mask),
		.result_valid (result_valid),
		.result       (result),
		.fail_count   (fail_count)
	);

endmodule

//--- source/csr_rule_check.sv
// Stage 3 of the CSR-write monitor, evaluates the six CSR rules and counts failing instructions

module csr_rule_check import rvfi_csr_pkg::*; #(
	// Width of the saturating failure counter
	parameter int COUNT_W = 16
) (
	input  logic               clock,
	input  logic               rst_n,
	input  logic               mask_valid,
	input  csr_mask_t          mask,
	output logic               result_valid,
	output csr_result_t        result,
	output logic [COUNT_W-1:0] fail_count
);

	// Rule outcome for the instruction currently in this stage
	csr_viol_t viol;

	// High when at least one rule failed
	logic any_fail;

	// High once the counter has reached its ceiling
	logic count_full;

	// Whether rd was written decides which read-side rules apply
	logic rd_is_x0;

	assign rd_is_x0 = (mask.rd_addr == 5'd0);

	always_comb begin
		// Writing x0 must not show a value, since x0 reads as zero
		viol.rd0_nonzero = rd_is_x0 && (mask.rd_wdata != '0);

		// A real destination needs the whole old CSR value, so every bit must be read
		viol.rmask_partial = !rd_is_x0 && (mask.rmask != '1);

		// The old value read from the CSR is what rd must receive
		viol.rdata_mismatch = !rd_is_x0 && (mask.rdata != mask.rd_wdata);

		// Every bit the instruction is meant to touch has to be visible in the write view
		viol.mask_uncovered = ((mask.smask | mask.cmask) & ~mask.eff_wmask) != '0;

		// Bits to be set must read as one afterwards
		viol.set_missing = (mask.smask & ~mask.eff_wdata) != '0;

		// Bits to be cleared must read as zero afterwards
		viol.clear_missing = (mask.cmask & mask.eff_wdata) != '0;
	end

	// Packed struct reduces like a plain vector
	assign any_fail = |viol;

	assign count_full = (fail_count == {COUNT_W{1'b1}});

	// Result strobe and failure counter share one register stage
	always_ff @(posedge clock or negedge rst_n) begin
		if (!rst_n) begin
			result_valid <= 1'b0;
			fail_count   <= '0;
		end else begin
			result_valid <= mask_valid;
			// Counter moves on the same edge that publishes the failing result
			if (mask_valid && any_fail && !count_full) begin
				fail_count <= fail_count + 1'b1;
			end
		end
	end

	// Flags and order tag travel together so the consumer can match them to the retire stream
	always_ff @(posedge clock) begin
		if (mask_valid) begin
			result.order <= mask.order;
			result.viol  <= viol;
		end
	end

endmodule

//--- source/csr_mask_calc.sv
// Stage 2 of the CSR-write monitor, builds set, clear and effective masks for each CSR instruction

module csr_mask_calc import rvfi_csr_pkg::*; (
	input  logic      clock,
	input  logic      rst_n,
	input  logic      dec_valid,
	input  csr_dec_t  dec,
	output logic      mask_valid,
	output csr_mask_t mask
);

	// Bits the instruction requires to end up set or cleared
	logic [XLEN-1:0] smask;
	logic [XLEN-1:0] cmask;

	// Write view of the CSR after merging what was read and what was written
	logic [XLEN-1:0] eff_wmask;
	logic [XLEN-1:0] eff_wdata;

	// The masks come from the operand, not from the written data
	// CSRRW forces every operand one to be set and every operand zero to be cleared
	always_comb begin
		smask = '0;
		cmask = '0;
		case (dec.op)
			F3_RW: begin
				smask = dec.operand;
				cmask = ~dec.operand;
			end
			F3_RS: begin
				smask = dec.operand;
			end
			F3_RC: begin
				cmask = dec.operand;
			end
			default: begin
				// op of zero never passes decode, so both masks stay empty
				smask = '0;
				cmask = '0;
			end
		endcase
	end

	// A bit that was read but not written is known to keep its old value
	assign eff_wmask = dec.csr_rmask | dec.csr_wmask;

	// Written bits take the new data, all other bits keep the read data
	assign eff_wdata = (dec.csr_wdata & dec.csr_wmask) | (dec.csr_rdata & ~dec.csr_wmask);

	always_ff @(posedge clock or negedge rst_n) begin
		if (!rst_n) begin
			mask_valid <= 1'b0;
		end else begin
			mask_valid <= dec_valid;
		end
	end

	// Payload is captured only for a live instruction
	always_ff @(posedge clock) begin
		if (dec_valid) begin
			mask.order     <= dec.order;
			mask.rd_addr   <= dec.rd_addr;
			mask.rd_wdata  <= dec.rd_wdata;
			mask.rmask     <= dec.csr_rmask;
			mask.rdata     <= dec.csr_rdata;
			mask.smask     <= smask;
			mask.cmask     <= cmask;
			mask.eff_wmask <= eff_wmask;
			mask.eff_wdata <= eff_wdata;
		end
	end

endmodule

//--- source/csr_insn_decode.sv
// Stage 1 of the CSR-write monitor, keeps only CSR instructions that target the monitored CSR

module csr_insn_decode import rvfi_csr_pkg::*; #(
	// Index of the CSR under check, mcycle by default
	parameter logic [11:0] CSR_ADDR = 12'hB00
) (
	input  logic      clock,
	input  logic      rst_n,
	input  rvfi_pkt_t rvfi,
	output logic      dec_valid,
	output csr_dec_t  dec
);

	// Individual terms of the acceptance test
	logic is_system;
	logic has_csr_op;
	logic addr_hit;
	logic accept;

	// Operand as the instruction supplies it to the CSR unit
	logic [XLEN-1:0] operand;

	// Immediate field of the I forms, which occupies the rs1 slot
	logic [4:0] uimm;

	// Opcode match also rules out compressed encodings, since their low bits differ
	assign is_system = (rvfi.insn[6:0] == OPC_SYSTEM);

	// funct3 bits 13:12 of zero mean ECALL, EBREAK, xRET, WFI and similar
	assign has_csr_op = (rvfi.insn[13:12] != 2'b00);

	// CSR index sits in the I-type immediate field
	assign addr_hit = (rvfi.insn[31:20] == CSR_ADDR);

	// Anything that fails here is simply dropped, so no result is ever produced for it
	assign accept = rvfi.valid && is_system && has_csr_op && addr_hit;

	assign uimm = rvfi.insn[19:15];

	// Bit 14 picks CSRRWI, CSRRSI or CSRRCI, where the 5-bit immediate is zero-extended
	// The register forms use the value read from rs1 instead
	assign operand = rvfi.insn[14] ? {{(XLEN-5){1'b0}}, uimm} : rvfi.rs1_rdata;

	// Valid strobe follows every sampled packet, so a rejected packet clears it
	always_ff @(posedge clock or negedge rst_n) begin
		if (!rst_n) begin
			dec_valid <= 1'b0;
		end else begin
			dec_valid <= accept;
		end
	end

	// Payload only loads on an accepted packet and otherwise holds its old value
	// Downstream stages look at it only when dec_valid is high
	always_ff @(posedge clock) begin
		if (accept) begin
			dec.order     <= rvfi.order;
			dec.op        <= rvfi.insn[13:12];
			dec.operand   <= operand;
			dec.rd_addr   <= rvfi.rd_addr;
			dec.rd_wdata  <= rvfi.rd_wdata;
			dec.csr_rmask <= rvfi.csr_rmask;
			dec.csr_wmask <= rvfi.csr_wmask;
			dec.csr_rdata <= rvfi.csr_rdata;
			dec.csr_wdata <= rvfi.csr_wdata;
		end
	end

endmodule

//--- source/rvfi_csr_pkg.sv
// Shared constants and packed structs for the RVFI CSR-write monitor, imported by every stage

package rvfi_csr_pkg;

	// Register width of the monitored core
	localparam int XLEN = 32;

	// SYSTEM major opcode, which carries all of the Zicsr instructions
	localparam logic [6:0] OPC_SYSTEM = 7'b1110011;

	// Operation codes as found in funct3 bits 13:12
	// Bit 14 only selects the immediate form and is handled separately
	localparam logic [1:0] F3_RW = 2'b01;
	localparam logic [1:0] F3_RS = 2'b10;
	localparam logic [1:0] F3_RC = 2'b11;

	// One retired instruction as presented on the RVFI port
	// Only the fields needed for the CSR checks are carried
	typedef struct packed {
		logic            valid;
		logic [15:0]     order;
		logic [31:0]     insn;
		logic [XLEN-1:0] rs1_rdata;
		logic [4:0]      rd_addr;
		logic [XLEN-1:0] rd_wdata;
		logic [XLEN-1:0] csr_rmask;
		logic [XLEN-1:0] csr_wmask;
		logic [XLEN-1:0] csr_rdata;
		logic [XLEN-1:0] csr_wdata;
	} rvfi_pkt_t;

	// Decoded CSR instruction, with the operand already selected
	typedef struct packed {
		logic [15:0]     order;
		logic [1:0]      op;
		logic [XLEN-1:0] operand;
		logic [4:0]      rd_addr;
		logic [XLEN-1:0] rd_wdata;
		logic [XLEN-1:0] csr_rmask;
		logic [XLEN-1:0] csr_wmask;
		logic [XLEN-1:0] csr_rdata;
		logic [XLEN-1:0] csr_wdata;
	} csr_dec_t;

	// Masks and effective values that the rule stage compares against
	typedef struct packed {
		logic [15:0]     order;
		logic [4:0]      rd_addr;
		logic [XLEN-1:0] rd_wdata;
		logic [XLEN-1:0] rmask;
		logic [XLEN-1:0] rdata;
		logic [XLEN-1:0] smask;
		logic [XLEN-1:0] cmask;
		logic [XLEN-1:0] eff_wmask;
		logic [XLEN-1:0] eff_wdata;
	} csr_mask_t;

	// One flag per rule, set when that rule fails
	typedef struct packed {
		logic rd0_nonzero;
		logic rmask_partial;
		logic rdata_mismatch;
		logic mask_uncovered;
		logic set_missing;
		logic clear_missing;
	} csr_viol_t;

	// Checked result, tagged with the retire order of its instruction
	typedef struct packed {
		logic [15:0] order;
		csr_viol_t   viol;
	} csr_result_t;

endpackage
